// ==== common/ifs_ctrl_pkg.sv ====
// Control-side definitions for the instruction fetch stage
// Widths, fixed debug addresses, PC select and prefetch state encodings
package ifs_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  // Address and instruction width
  localparam int unsigned addr_w = 32;

  // Fetch FIFO entries and derived counter widths
  localparam int unsigned fifo_depth = 2;
  localparam int unsigned cnt_w      = $clog2(fifo_depth + 1);
  localparam int unsigned ptr_w      = $clog2(fifo_depth);

  //////////////////////////////////////////////////////////////////////
  // Fixed addresses
  //////////////////////////////////////////////////////////////////////

  // Low byte of the reset vector, above the 256 byte aligned boot base
  localparam logic [7:0] boot_offset = 8'h80;

  // Debug module entry points
  localparam logic [addr_w-1:0] dm_halt_addr = 32'h1A11_0800;
  localparam logic [addr_w-1:0] dm_exc_addr  = 32'h1A11_0808;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Source of the next PC on a PC set
  typedef enum logic [2:0] {
    pc_boot = 3'd0,
    pc_jump = 3'd1,
    pc_exc  = 3'd2,
    pc_eret = 3'd3,
    pc_dret = 3'd4
  } pc_sel_e;

  // Target when the PC source is an exception
  typedef enum logic [1:0] {
    exc_pc_exc      = 2'd0,
    exc_pc_irq      = 2'd1,
    exc_pc_dbg_halt = 2'd2,
    exc_pc_dbg_exc  = 2'd3
  } exc_pc_sel_e;

  // Prefetch sequencing, one read in flight at most
  typedef enum logic [1:0] {
    fetch_idle = 2'd0,
    fetch_req  = 2'd1,
    fetch_wait = 2'd2
  } fetch_state_e;

endpackage

// ==== common/ifs_data_pkg.sv ====
// Data-side types for the instruction fetch stage
// Bus read request, fetched FIFO entry and the decode-stage view
package ifs_data_pkg;

  // Read request on the instruction bus
  typedef struct packed {
    logic                                 req;
    logic [ifs_ctrl_pkg::addr_w-1:0]      addr;
  } bus_req_t;

  // One fetched word as it sits in the FIFO
  typedef struct packed {
    logic [ifs_ctrl_pkg::addr_w-1:0]      rdata;
    logic [ifs_ctrl_pkg::addr_w-1:0]      addr;
    // Bus error reported with the response
    logic                                 err;
  } fetch_entry_t;

  // Contents of the IF-ID register
  typedef struct packed {
    logic [ifs_ctrl_pkg::addr_w-1:0]      instr;
    logic [ifs_ctrl_pkg::addr_w-1:0]      pc;
    logic                                 fetch_err;
  } id_out_t;

endpackage

// ==== fetch/fetch_addr_cnt.sv ====
// Fetch address counter
// Next word address to read, loaded on a branch, stepped per granted read
module fetch_addr_cnt (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              load_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   target_i,
  input  logic                              step_i,
  output logic [ifs_ctrl_pkg::addr_w-1:0]   addr_o
);

  logic [ifs_ctrl_pkg::addr_w-1:0] addr_q, addr_d;

  // Load wins over step, reads are always word aligned
  always_comb begin
    addr_d = addr_q;
    if (load_i) begin
      addr_d = {target_i[ifs_ctrl_pkg::addr_w-1:2], 2'b00};
    end else if (step_i) begin
      addr_d = addr_q + ifs_ctrl_pkg::addr_w'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr_d;
    end
  end

  assign addr_o = addr_q;

endmodule

// ==== fetch/fetch_fifo.sv ====
// Fetch FIFO
// In-order queue of fetched words with address and error, flushed on branch
module fetch_fifo (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              push_i,
  input  ifs_data_pkg::fetch_entry_t        push_data_i,
  input  logic                              ready_i,
  output logic                              valid_o,
  output ifs_data_pkg::fetch_entry_t        data_o,
  output logic [ifs_ctrl_pkg::cnt_w-1:0]    count_o
);

  ifs_data_pkg::fetch_entry_t       mem_q [ifs_ctrl_pkg::fifo_depth];
  logic [ifs_ctrl_pkg::ptr_w-1:0]   wr_ptr_q, rd_ptr_q;
  logic [ifs_ctrl_pkg::cnt_w-1:0]   count_q;
  logic                             pop;

  assign pop = valid_o & ready_i;

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Branch drops everything queued, including a same-cycle push
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the level unchanged
      count_q <= count_q + ifs_ctrl_pkg::cnt_w'(push_i) - ifs_ctrl_pkg::cnt_w'(pop);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Head of queue, visible the cycle after its push
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign count_o = count_q;

endmodule

// ==== fetch/fetch_fsm.sv ====
// Prefetch state machine
// Issues bus reads, tracks the outstanding address and drops stale responses
module fetch_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic                              pc_set_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   addr_i,
  input  logic                              gnt_i,
  input  logic                              rvalid_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   rdata_i,
  input  logic                              bus_err_i,
  input  logic [ifs_ctrl_pkg::cnt_w-1:0]    fifo_count_i,
  output ifs_data_pkg::bus_req_t            bus_o,
  output logic                              step_o,
  output logic                              push_o,
  output ifs_data_pkg::fetch_entry_t        push_data_o,
  output logic                              flush_o,
  output logic                              busy_o
);

  ifs_ctrl_pkg::fetch_state_e      state_q, state_d;
  logic                            discard_q, discard_d;
  logic [ifs_ctrl_pkg::addr_w-1:0] rd_addr_q;
  logic                            in_req, resp;
  logic                            room_idle, room_resp;

  assign in_req = (state_q == ifs_ctrl_pkg::fetch_req);
  assign resp   = (state_q == ifs_ctrl_pkg::fetch_wait) & rvalid_i;

  // A branch empties the FIFO, so there is always room after it
  assign room_idle = pc_set_i | (fifo_count_i < ifs_ctrl_pkg::fifo_depth);
  // Count the word being pushed now, pops only show up a cycle later
  assign room_resp = pc_set_i | ((fifo_count_i + push_o) < ifs_ctrl_pkg::fifo_depth);

  always_comb begin
    state_d   = state_q;
    discard_d = discard_q;
    unique case (state_q)
      ifs_ctrl_pkg::fetch_idle: begin
        if (req_i && room_idle) begin
          state_d = ifs_ctrl_pkg::fetch_req;
        end
      end
      // Request stays up until granted, whatever req_i does
      ifs_ctrl_pkg::fetch_req: begin
        if (gnt_i) begin
          state_d = ifs_ctrl_pkg::fetch_wait;
        end
      end
      ifs_ctrl_pkg::fetch_wait: begin
        if (rvalid_i) begin
          state_d = (req_i && room_resp) ? ifs_ctrl_pkg::fetch_req : ifs_ctrl_pkg::fetch_idle;
        end
      end
      default: state_d = ifs_ctrl_pkg::fetch_idle;
    endcase
    // Response ends the read, otherwise a branch poisons it
    if (resp) begin
      discard_d = 1'b0;
    end else if (pc_set_i && (state_q != ifs_ctrl_pkg::fetch_idle)) begin
      discard_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ifs_ctrl_pkg::fetch_idle;
      discard_q <= 1'b0;
      rd_addr_q <= '0;
    end else begin
      state_q   <= state_d;
      discard_q <= discard_d;
      // Track the counter while requesting, freeze once poisoned or granted
      if (in_req && !discard_q) begin
        rd_addr_q <= addr_i;
      end
    end
  end

  // Bus address stays on the old path until the poisoned read is granted
  assign bus_o.req  = in_req;
  assign bus_o.addr = (in_req && !discard_q) ? addr_i : rd_addr_q;

  // Counter moves on only for reads of the current path
  assign step_o = in_req & gnt_i & ~discard_q;

  assign push_o            = resp & ~discard_q;
  assign push_data_o.rdata = rdata_i;
  assign push_data_o.addr  = rd_addr_q;
  assign push_data_o.err   = bus_err_i;

  assign flush_o = pc_set_i;
  assign busy_o  = (state_q != ifs_ctrl_pkg::fetch_idle);

endmodule

// ==== logic/if_id_reg.sv ====
// IF-ID pipeline register
// Valid, new and clear control plus the held instruction, PC and error
module if_id_reg (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              valid_i,
  input  ifs_data_pkg::fetch_entry_t        data_i,
  input  logic                              id_in_ready_i,
  input  logic                              pc_set_i,
  input  logic                              instr_valid_clear_i,
  output logic                              ready_o,
  output logic                              instr_valid_id_o,
  output logic                              instr_new_id_o,
  output ifs_data_pkg::id_out_t             id_o
);

  logic valid_q, valid_d;
  logic new_q;
  logic accept;

  // Frozen while decode stalls, the FIFO holds its head meanwhile
  assign ready_o = id_in_ready_i;
  assign accept  = valid_i & id_in_ready_i;

  // Entry arriving with a branch is squashed
  // Valid then stays until decode clears it
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // One cycle marker for each accepted entry
      new_q   <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_o.instr     <= data_i.rdata;
      id_o.pc        <= data_i.addr;
      id_o.fetch_err <= data_i.err;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// ==== logic/if_stage_top.sv ====
// Instruction fetch stage top level
// Next-PC selection, prefetch engine and IF-ID register
module if_stage_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   boot_addr_i,
  input  logic                              pc_set_i,
  input  ifs_ctrl_pkg::pc_sel_e             pc_mux_i,
  input  ifs_ctrl_pkg::exc_pc_sel_e         exc_pc_mux_i,
  input  logic [4:0]                        irq_id_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   branch_target_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   csr_mepc_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   csr_depc_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   csr_mtvec_i,
  // Instruction bus
  output logic                              instr_req_o,
  output logic [ifs_ctrl_pkg::addr_w-1:0]   instr_addr_o,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   instr_rdata_i,
  input  logic                              instr_bus_err_i,
  // Decode stage side
  input  logic                              id_in_ready_i,
  input  logic                              instr_valid_clear_i,
  output logic                              instr_valid_id_o,
  output logic                              instr_new_id_o,
  output logic [ifs_ctrl_pkg::addr_w-1:0]   instr_rdata_id_o,
  output logic [ifs_ctrl_pkg::addr_w-1:0]   pc_id_o,
  output logic                              instr_fetch_err_o,
  output logic                              csr_mtvec_init_o,
  output logic                              if_busy_o
);

  logic [ifs_ctrl_pkg::addr_w-1:0] target_addr, fetch_addr;
  logic [ifs_ctrl_pkg::cnt_w-1:0]  fifo_count;
  logic                            step, push, flush, fifo_valid, fifo_ready;
  ifs_data_pkg::bus_req_t          bus_req;
  ifs_data_pkg::fetch_entry_t      push_data, fifo_data;
  ifs_data_pkg::id_out_t           id_out;

  pc_target_mux u_pc_target_mux (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (irq_id_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .target_addr_o    (target_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_addr_cnt u_fetch_addr_cnt (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .load_i   (pc_set_i),
    .target_i (target_addr),
    .step_i   (step),
    .addr_o   (fetch_addr)
  );

  fetch_fsm u_fetch_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .pc_set_i     (pc_set_i),
    .addr_i       (fetch_addr),
    .gnt_i        (instr_gnt_i),
    .rvalid_i     (instr_rvalid_i),
    .rdata_i      (instr_rdata_i),
    .bus_err_i    (instr_bus_err_i),
    .fifo_count_i (fifo_count),
    .bus_o        (bus_req),
    .step_o       (step),
    .push_o       (push),
    .push_data_o  (push_data),
    .flush_o      (flush),
    .busy_o       (if_busy_o)
  );

  fetch_fifo u_fetch_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush),
    .push_i      (push),
    .push_data_i (push_data),
    .ready_i     (fifo_ready),
    .valid_o     (fifo_valid),
    .data_o      (fifo_data),
    .count_o     (fifo_count)
  );

  if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .valid_i             (fifo_valid),
    .data_i              (fifo_data),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .ready_o             (fifo_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_o                (id_out)
  );

  // Unbundle for the bus and decode ports
  assign instr_req_o       = bus_req.req;
  assign instr_addr_o      = bus_req.addr;
  assign instr_rdata_id_o  = id_out.instr;
  assign pc_id_o           = id_out.pc;
  assign instr_fetch_err_o = id_out.fetch_err;

endmodule

// ==== logic/pc_target_mux.sv ====
// Next-PC selection
// Exception and interrupt vector, return addresses, boot vector, mtvec init
module pc_target_mux (
  input  ifs_ctrl_pkg::pc_sel_e             pc_mux_i,
  input  ifs_ctrl_pkg::exc_pc_sel_e         exc_pc_mux_i,
  input  logic [4:0]                        irq_id_i,
  input  logic                              pc_set_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   boot_addr_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   branch_target_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   csr_mepc_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   csr_depc_i,
  input  logic [ifs_ctrl_pkg::addr_w-1:0]   csr_mtvec_i,
  output logic [ifs_ctrl_pkg::addr_w-1:0]   target_addr_o,
  output logic                              csr_mtvec_init_o
);

  logic [ifs_ctrl_pkg::addr_w-1:0] exc_pc;

  // Vectored mode, each interrupt line gets one word above the base
  always_comb begin
    unique case (exc_pc_mux_i)
      ifs_ctrl_pkg::exc_pc_exc:      exc_pc = {csr_mtvec_i[31:8], 8'h00};
      ifs_ctrl_pkg::exc_pc_irq:      exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_id_i, 2'b00};
      ifs_ctrl_pkg::exc_pc_dbg_halt: exc_pc = ifs_ctrl_pkg::dm_halt_addr;
      ifs_ctrl_pkg::exc_pc_dbg_exc:  exc_pc = ifs_ctrl_pkg::dm_exc_addr;
      default:                       exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      ifs_ctrl_pkg::pc_boot: target_addr_o = {boot_addr_i[31:8], ifs_ctrl_pkg::boot_offset};
      ifs_ctrl_pkg::pc_jump: target_addr_o = branch_target_i;
      ifs_ctrl_pkg::pc_exc:  target_addr_o = exc_pc;
      // Back from a trap or from debug mode
      ifs_ctrl_pkg::pc_eret: target_addr_o = csr_mepc_i;
      ifs_ctrl_pkg::pc_dret: target_addr_o = csr_depc_i;
      default:               target_addr_o = {boot_addr_i[31:8], ifs_ctrl_pkg::boot_offset};
    endcase
  end

  // CSR file loads mtvec from the boot base on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == ifs_ctrl_pkg::pc_boot);

endmodule

// ==== sources.f ====
common/ifs_ctrl_pkg.sv
common/ifs_data_pkg.sv
fetch/fetch_addr_cnt.sv
fetch/fetch_fsm.sv
fetch/fetch_fifo.sv
logic/pc_target_mux.sv
logic/if_id_reg.sv
logic/if_stage_top.sv
verif/tb_if_stage.sv

// ==== verif/tb_if_stage.sv ====
// Testbench for the instruction fetch stage
// Bus memory model with random grant and response delays, reference data,
// expected PC tracking and directed tests for flush, vectors and stalls
module tb_if_stage;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_tests     = 6;
  localparam int cycle_limit = n_tests * 200;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               req_i;
  logic [31:0]                        boot_addr_i;
  logic                               pc_set_i;
  ifs_ctrl_pkg::pc_sel_e              pc_mux_i;
  ifs_ctrl_pkg::exc_pc_sel_e          exc_pc_mux_i;
  logic [4:0]                         irq_id_i;
  logic [31:0]                        branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  logic                               instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0]                        instr_addr_o, instr_rdata_i;
  logic                               instr_bus_err_i;
  logic                               id_in_ready_i, instr_valid_clear_i;
  logic                               instr_valid_id_o, instr_new_id_o;
  logic [31:0]                        instr_rdata_id_o, pc_id_o;
  logic                               instr_fetch_err_o, csr_mtvec_init_o, if_busy_o;

  // Bookkeeping shared by the stimulus, the model and the compare process
  logic [31:0] lfsr_q;
  logic [31:0] exp_pc;
  logic [31:0] err_table [2];
  int          n_acc, checks, errors, err_start, chk_start, cycles;
  string       test_name;

  // Memory model state
  int          gnt_wait, rsp_wait;
  logic        rsp_pend;
  logic [31:0] rsp_addr, req_addr;

  if_stage_top u_if_stage_top (.*);

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Reference model and random source
  //////////////////////////////////////////////////////////////////////

  // Memory contents follow the address
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return addr ^ 32'hA5C3_0F96;
  endfunction

  function automatic logic in_err_table(input logic [31:0] addr);
    return (addr == err_table[0]) || (addr == err_table[1]);
  endfunction

  // First PC of the new path for a given selection
  function automatic logic [31:0] vector_target(input ifs_ctrl_pkg::pc_sel_e sel,
                                                input ifs_ctrl_pkg::exc_pc_sel_e esel);
    logic [31:0] base;
    logic [31:0] t;
    base = csr_mtvec_i & 32'hFFFF_FF00;
    case (sel)
      ifs_ctrl_pkg::pc_boot: t = (boot_addr_i & 32'hFFFF_FF00) + 32'h80;
      ifs_ctrl_pkg::pc_jump: t = branch_target_i;
      ifs_ctrl_pkg::pc_eret: t = csr_mepc_i;
      ifs_ctrl_pkg::pc_dret: t = csr_depc_i;
      default:               t = base;
    endcase
    if (sel == ifs_ctrl_pkg::pc_exc) begin
      if (esel == ifs_ctrl_pkg::exc_pc_irq) t = base + 32'd4 * irq_id_i;
      if (esel == ifs_ctrl_pkg::exc_pc_dbg_halt) t = ifs_ctrl_pkg::dm_halt_addr;
      if (esel == ifs_ctrl_pkg::exc_pc_dbg_exc) t = ifs_ctrl_pkg::dm_exc_addr;
    end
    // Fetch is word aligned
    return t & ~32'h3;
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[0] ^ s[10] ^ s[30] ^ s[31], s[31:1]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic require_true(input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("ERROR in %s: %s", test_name, msg);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Instruction bus memory model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      gnt_wait = -1;
      rsp_pend = 1'b0;
    end else begin
      // Busy while requesting or while a granted read still owes its response
      require_true(if_busy_o == (instr_req_o || rsp_pend || instr_rvalid_i),
                   "if_busy_o does not follow the bus activity");
      instr_rvalid_i <= 1'b0;
      if (instr_req_o && instr_gnt_i) begin
        // Schedule the single response once granted
        instr_gnt_i <= 1'b0;
        gnt_wait = -1;
        rsp_pend = 1'b1;
        rsp_addr = instr_addr_o;
        rsp_wait = int'(rand_bits(2) % 3);
      end else if (instr_req_o) begin
        if (gnt_wait < 0) begin
          req_addr = instr_addr_o;
          gnt_wait = int'(rand_bits(2) % 3);
        end else begin
          require_true(instr_addr_o == req_addr, "instr_addr_o changed before the grant");
        end
        if (gnt_wait == 0) begin
          instr_gnt_i <= 1'b1;
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end
      if (rsp_pend) begin
        if (rsp_wait == 0) begin
          instr_rvalid_i  <= 1'b1;
          instr_rdata_i   <= ref_word(rsp_addr);
          instr_bus_err_i <= in_err_table(rsp_addr);
          rsp_pend = 1'b0;
        end else begin
          rsp_wait = rsp_wait - 1;
        end
      end
    end
  end

  // Every accepted instruction must continue the expected PC sequence
  always @(negedge clk_i) begin
    if (rst_ni && instr_new_id_o && instr_valid_id_o) begin
      compare_value("pc", exp_pc, pc_id_o);
      compare_value("instr", ref_word(exp_pc), instr_rdata_id_o);
      compare_value("fetch_err", {31'b0, in_err_table(exp_pc)}, {31'b0, instr_fetch_err_o});
      exp_pc = exp_pc + 32'd4;
      n_acc++;
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic start_test(input string name);
    @(posedge clk_i);
    test_name = name;
    err_start = errors;
    chk_start = checks;
  endtask

  task automatic end_test();
    $display("test %s done, %0d checks, %0d errors", test_name, checks - chk_start,
             errors - err_start);
  endtask

  // Called right after a rising edge, returns right after one
  task automatic set_pc(input ifs_ctrl_pkg::pc_sel_e sel, input ifs_ctrl_pkg::exc_pc_sel_e esel);
    logic [31:0] target;
    req_i               <= 1'b1;
    pc_set_i            <= 1'b1;
    pc_mux_i            <= sel;
    exc_pc_mux_i        <= esel;
    instr_valid_clear_i <= 1'b1;
    @(negedge clk_i);
    target = vector_target(sel, esel);
    require_true(csr_mtvec_init_o == (sel == ifs_ctrl_pkg::pc_boot),
                 "csr_mtvec_init_o wrong during the PC set");
    @(posedge clk_i);
    pc_set_i            <= 1'b0;
    instr_valid_clear_i <= 1'b0;
    exp_pc = target;
    @(negedge clk_i);
    require_true(!instr_valid_id_o, "instr_valid_id_o high right after the PC set");
    require_true(!csr_mtvec_init_o, "csr_mtvec_init_o high for more than one cycle");
    @(posedge clk_i);
  endtask

  task automatic wait_accepts(input int n);
    int goal;
    goal = n_acc + n;
    while (n_acc < goal) @(posedge clk_i);
  endtask

  task automatic vector_case(input ifs_ctrl_pkg::pc_sel_e sel,
                             input ifs_ctrl_pkg::exc_pc_sel_e esel, input logic [4:0] irq);
    irq_id_i <= irq;
    set_pc(sel, esel);
    wait_accepts(2);
  endtask

  // Stall decode for a random time and check that the outputs freeze
  task automatic hold_ready();
    int          len;
    int          i;
    logic [31:0] pc_hold, instr_hold;
    logic        err_hold;
    @(negedge clk_i);
    len = 4 + int'(rand_bits(4));
    @(posedge clk_i);
    id_in_ready_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    pc_hold    = pc_id_o;
    instr_hold = instr_rdata_id_o;
    err_hold   = instr_fetch_err_o;
    for (i = 0; i < len; i++) begin
      @(negedge clk_i);
      require_true(!instr_new_id_o, "instr_new_id_o high while decode is stalled");
      compare_value("held pc", pc_hold, pc_id_o);
      compare_value("held instr", instr_hold, instr_rdata_id_o);
      compare_value("held fetch_err", {31'b0, err_hold}, {31'b0, instr_fetch_err_o});
    end
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    boot_addr_i         = 32'h0000_1000;
    pc_set_i            = 1'b0;
    pc_mux_i            = ifs_ctrl_pkg::pc_boot;
    exc_pc_mux_i        = ifs_ctrl_pkg::exc_pc_exc;
    irq_id_i            = 5'd0;
    branch_target_i     = 32'h0;
    csr_mepc_i          = 32'h0000_4406;
    csr_depc_i          = 32'h0000_6000;
    csr_mtvec_i         = 32'h0000_5001;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = 32'h0;
    instr_bus_err_i     = 1'b0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    lfsr_q              = 32'd76890;
    err_table[0]        = 32'h0000_3008;
    err_table[1]        = 32'h0000_3010;
    exp_pc              = 32'h0;
    n_acc               = 0;
    checks              = 0;
    errors              = 0;
    cycles              = 0;
    test_name           = "reset";
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test("reset_boot");
    @(negedge clk_i);
    require_true(!instr_req_o && !instr_valid_id_o, "instr_req_o or instr_valid_id_o high");
    require_true(!instr_new_id_o && !csr_mtvec_init_o, "instr_new_id_o or mtvec init high");
    @(posedge clk_i);
    set_pc(ifs_ctrl_pkg::pc_boot, ifs_ctrl_pkg::exc_pc_exc);
    wait_accepts(4);
    end_test();

    start_test("jump_flush");
    branch_target_i <= 32'h0000_2000;
    while (!instr_req_o) @(posedge clk_i);
    set_pc(ifs_ctrl_pkg::pc_jump, ifs_ctrl_pkg::exc_pc_exc);
    wait_accepts(3);
    // Second jump lands while a response is still due
    branch_target_i <= 32'h0000_2800;
    while (!(if_busy_o && !instr_req_o)) @(posedge clk_i);
    set_pc(ifs_ctrl_pkg::pc_jump, ifs_ctrl_pkg::exc_pc_exc);
    wait_accepts(3);
    end_test();

    start_test("vectors");
    vector_case(ifs_ctrl_pkg::pc_exc, ifs_ctrl_pkg::exc_pc_exc, 5'd0);
    vector_case(ifs_ctrl_pkg::pc_eret, ifs_ctrl_pkg::exc_pc_exc, 5'd0);
    vector_case(ifs_ctrl_pkg::pc_dret, ifs_ctrl_pkg::exc_pc_exc, 5'd0);
    vector_case(ifs_ctrl_pkg::pc_exc, ifs_ctrl_pkg::exc_pc_irq, 5'd3);
    vector_case(ifs_ctrl_pkg::pc_exc, ifs_ctrl_pkg::exc_pc_irq, 5'd11);
    vector_case(ifs_ctrl_pkg::pc_exc, ifs_ctrl_pkg::exc_pc_irq, 5'd31);
    vector_case(ifs_ctrl_pkg::pc_exc, ifs_ctrl_pkg::exc_pc_dbg_halt, 5'd0);
    vector_case(ifs_ctrl_pkg::pc_exc, ifs_ctrl_pkg::exc_pc_dbg_exc, 5'd0);
    end_test();

    start_test("back_pressure");
    wait_accepts(2);
    hold_ready();
    wait_accepts(4);
    end_test();

    start_test("bus_error");
    branch_target_i <= 32'h0000_3000;
    set_pc(ifs_ctrl_pkg::pc_jump, ifs_ctrl_pkg::exc_pc_exc);
    wait_accepts(6);
    end_test();

    start_test("valid_clear");
    wait_accepts(2);
    id_in_ready_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    require_true(instr_valid_id_o, "instr_valid_id_o low before the clear");
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b1;
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b0;
    @(negedge clk_i);
    require_true(!instr_valid_id_o, "instr_valid_id_o still high after the clear");
    require_true(!instr_new_id_o, "instr_new_id_o high without an accept");
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
    wait_accepts(2);
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
